// ==== include/gba_io_cfg.svh ====
// Register map and sizing of the I/O block.
// Included by the RTL modules that decode register words or
// count timers and interrupt sources.

`ifndef GBA_IO_CFG_SVH
`define GBA_IO_CFG_SVH

// Timer words, reload or count in the low half, control in the high half
`define TM0_IDX         4'd0
`define TM1_IDX         4'd1
`define TM2_IDX         4'd2
`define TM3_IDX         4'd3

// IE in the low half, IF in the high half
`define IE_IF_IDX       4'd4
`define IME_IDX         4'd5
`define KEYINPUT_IDX    4'd6

// Debug words shown on the LEDs
`define LED_REG0_IDX    4'd8
`define LED_REG1_IDX    4'd9
`define LED_REG2_IDX    4'd10
`define LED_REG3_IDX    4'd11

`define NUM_IO_REGS     16
`define NUM_TIMERS      4

// Interrupt flag positions, timers 0 to 3 take four bits from here
`define IRQ_TIMER0_BIT  3
`define IRQ_KEYPAD_BIT  12

`endif

// ==== rtl/gba_io_pkg.sv ====
// Types for the register bus and the interrupt and keypad vectors.
// Referenced by scoped name from the register bank, the interrupt
// controller, the LED selector and the top level.

package gba_io_pkg;

    // One bus or register word
    typedef logic [31:0] io_data_t;

    // Word index on the register bus
    typedef logic [3:0] io_index_t;

    // IE, IF and acknowledge vectors share one layout
    typedef logic [15:0] irq_vec_t;

    // Button levels, a pressed button reads 0
    typedef logic [15:0] keys_t;

endpackage

// ==== rtl/gba_timer_pkg.sv ====
// Types for the timers: count and reload values, the control
// half-word and its prescaler encoding.

package gba_timer_pkg;

    typedef logic [15:0] tm_count_t;

    // Control half-word, bits 1:0 pick the prescaler
    typedef logic [15:0] tm_ctrl_t;

    localparam int TM_CASCADE_BIT = 2;
    localparam int TM_IRQ_EN_BIT  = 6;
    localparam int TM_ENABLE_BIT  = 7;

    typedef enum logic [1:0] {
        PRESCALE_1    = 2'd0,
        PRESCALE_64   = 2'd1,
        PRESCALE_256  = 2'd2,
        PRESCALE_1024 = 2'd3
    } prescale_t;

endpackage

// ==== rtl/io_reg_bank.sv ====
// Register bank of the I/O block. Writes land at the clock edge where
// bus_write is high; read data follows bus_index combinationally.
// Timer words read the live count, the IE/IF word reads the flags from
// the interrupt controller, and a write there also acknowledges flags.
`timescale 1ns/1ns

`include "gba_io_cfg.svh"

module io_reg_bank (
    input  logic                     clock,
    input  logic                     reset,
    input  gba_io_pkg::io_index_t    bus_index,
    input  gba_io_pkg::io_data_t     bus_wdata,
    input  logic                     bus_write,
    output gba_io_pkg::io_data_t     bus_rdata,
    output gba_timer_pkg::tm_count_t tm_reload [`NUM_TIMERS],
    output gba_timer_pkg::tm_ctrl_t  tm_ctrl [`NUM_TIMERS],
    input  gba_timer_pkg::tm_count_t tm_count [`NUM_TIMERS],
    output gba_io_pkg::irq_vec_t     reg_ie,
    output logic                     ime,
    output gba_io_pkg::irq_vec_t     int_ack,
    input  gba_io_pkg::irq_vec_t     reg_if,
    input  gba_io_pkg::keys_t        buttons,
    output gba_io_pkg::io_data_t     led_reg0,
    output gba_io_pkg::io_data_t     led_reg1,
    output gba_io_pkg::io_data_t     led_reg2,
    output gba_io_pkg::io_data_t     led_reg3
);

    gba_io_pkg::io_data_t read_words [`NUM_IO_REGS];
    logic                 ack_write;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int t = 0; t < `NUM_TIMERS; t++) begin
                tm_reload[t] <= '0;
                tm_ctrl[t]   <= '0;
            end
            reg_ie   <= '0;
            ime      <= 1'b0;
            led_reg0 <= '0;
            led_reg1 <= '0;
            led_reg2 <= '0;
            led_reg3 <= '0;
        end else if (bus_write) begin
            case (bus_index)
                `TM0_IDX: begin
                    tm_reload[0] <= bus_wdata[15:0];
                    tm_ctrl[0]   <= bus_wdata[31:16];
                end
                `TM1_IDX: begin
                    tm_reload[1] <= bus_wdata[15:0];
                    tm_ctrl[1]   <= bus_wdata[31:16];
                end
                `TM2_IDX: begin
                    tm_reload[2] <= bus_wdata[15:0];
                    tm_ctrl[2]   <= bus_wdata[31:16];
                end
                `TM3_IDX: begin
                    tm_reload[3] <= bus_wdata[15:0];
                    tm_ctrl[3]   <= bus_wdata[31:16];
                end
                // High half is the acknowledge, handled below
                `IE_IF_IDX:    reg_ie   <= bus_wdata[15:0];
                `IME_IDX:      ime      <= bus_wdata[0];
                `LED_REG0_IDX: led_reg0 <= bus_wdata;
                `LED_REG1_IDX: led_reg1 <= bus_wdata;
                `LED_REG2_IDX: led_reg2 <= bus_wdata;
                `LED_REG3_IDX: led_reg3 <= bus_wdata;
                default: ;
            endcase
        end
    end

    // Acknowledge lives only for the write cycle
    assign ack_write = bus_write && (bus_index == `IE_IF_IDX);
    assign int_ack   = ack_write ? bus_wdata[31:16] : '0;

    always_comb begin
        for (int w = 0; w < `NUM_IO_REGS; w++) begin
            read_words[w] = '0;
        end
        read_words[`TM0_IDX]      = {tm_ctrl[0], tm_count[0]};
        read_words[`TM1_IDX]      = {tm_ctrl[1], tm_count[1]};
        read_words[`TM2_IDX]      = {tm_ctrl[2], tm_count[2]};
        read_words[`TM3_IDX]      = {tm_ctrl[3], tm_count[3]};
        read_words[`IE_IF_IDX]    = {reg_if, reg_ie};
        read_words[`IME_IDX]      = {31'd0, ime};
        read_words[`KEYINPUT_IDX] = {16'd0, buttons};
        read_words[`LED_REG0_IDX] = led_reg0;
        read_words[`LED_REG1_IDX] = led_reg1;
        read_words[`LED_REG2_IDX] = led_reg2;
        read_words[`LED_REG3_IDX] = led_reg3;
    end

    assign bus_rdata = read_words[bus_index];

    // No flag may be acknowledged outside an IE/IF write
    a_ack_only_on_write: assert property (
        @(posedge clock) disable iff (reset)
        !(bus_write && bus_index == `IE_IF_IDX) |-> (int_ack == '0)
    );

endmodule

// ==== rtl/timer_unit.sv ====
// One 16-bit timer. A rising edge of the enable bit loads the reload
// value one clock later and restarts the prescaler. The count then steps
// on prescaler ticks, or on cascade pulses in cascade mode, and wraps to
// the reload value with a one-cycle combinational overflow pulse.
`timescale 1ns/1ns

module timer_unit (
    input  logic                     clock,
    input  logic                     reset,
    input  gba_timer_pkg::tm_count_t reload,
    input  gba_timer_pkg::tm_ctrl_t  ctrl,
    input  logic                     cascade_in,
    output gba_timer_pkg::tm_count_t count,
    output logic                     overflow
);

    gba_timer_pkg::prescale_t prescale;
    logic [9:0]               presc_cnt;
    logic                     enable;
    logic                     enable_q;
    logic                     load;
    logic                     running;
    logic                     tick;
    logic                     inc_due;

    assign enable   = ctrl[gba_timer_pkg::TM_ENABLE_BIT];
    assign load     = enable && !enable_q;
    assign running  = enable && enable_q;
    assign prescale = gba_timer_pkg::prescale_t'(ctrl[1:0]);

    // Tick on the last cycle of each divider period
    always_comb begin
        unique case (prescale)
            gba_timer_pkg::PRESCALE_1:    tick = 1'b1;
            gba_timer_pkg::PRESCALE_64:   tick = &presc_cnt[5:0];
            gba_timer_pkg::PRESCALE_256:  tick = &presc_cnt[7:0];
            gba_timer_pkg::PRESCALE_1024: tick = &presc_cnt;
        endcase
    end

    assign inc_due  = running &&
                      (ctrl[gba_timer_pkg::TM_CASCADE_BIT] ? cascade_in : tick);
    assign overflow = inc_due && (count == 16'hFFFF);

    always_ff @(posedge clock) begin
        if (reset) begin
            enable_q  <= 1'b0;
            presc_cnt <= '0;
            count     <= '0;
        end else begin
            enable_q <= enable;
            if (load) begin
                count     <= reload;
                presc_cnt <= '0;
            end else if (running) begin
                presc_cnt <= presc_cnt + 10'd1;
                if (inc_due) begin
                    count <= overflow ? reload : count + 16'd1;
                end
            end
        end
    end

    a_hold_when_disabled: assert property (
        @(posedge clock) disable iff (reset)
        !enable |=> $stable(count)
    );

endmodule

// ==== rtl/interrupt_controller.sv ====
// Interrupt flags and the interrupt line to the CPU.
// Timer overflows and new button presses set IF bits, acknowledges from
// the register bank clear them, a request beating a clear at the same
// edge. nirq is registered and low while IME and any IE&IF bit are set.
`timescale 1ns/1ns

`include "gba_io_cfg.svh"

module interrupt_controller (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [`NUM_TIMERS-1:0] timer_irq,
    input  gba_io_pkg::keys_t     buttons,
    input  gba_io_pkg::irq_vec_t  reg_ie,
    input  logic                  ime,
    input  gba_io_pkg::irq_vec_t  int_ack,
    output gba_io_pkg::irq_vec_t  reg_if,
    output logic                  nirq
);

    gba_io_pkg::keys_t    buttons_q;
    gba_io_pkg::irq_vec_t irq_set;
    logic                 key_press;

    // Released last cycle and pressed now, levels are active low
    assign key_press = |(buttons_q & ~buttons);

    always_comb begin
        irq_set = '0;
        irq_set[`IRQ_TIMER0_BIT +: `NUM_TIMERS] = timer_irq;
        irq_set[`IRQ_KEYPAD_BIT] = key_press;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            buttons_q <= '0;
            reg_if    <= '0;
            nirq      <= 1'b1;
        end else begin
            buttons_q <= buttons;
            reg_if    <= (reg_if & ~int_ack) | irq_set;
            nirq      <= !(ime && |(reg_ie & reg_if));
        end
    end

    a_no_irq_without_ime: assert property (
        @(posedge clock) disable iff (reset)
        !ime |=> nirq
    );

endmodule

// ==== rtl/led_controller.sv ====
// Debug LED selector. Switch values 0 to F pick one byte of the four
// LED registers; any other value shows a button byte, inverted so that
// a pressed button lights its LED.
`timescale 1ns/1ns

module led_controller (
    input  logic [7:0]           sw,
    input  gba_io_pkg::io_data_t led_reg0,
    input  gba_io_pkg::io_data_t led_reg1,
    input  gba_io_pkg::io_data_t led_reg2,
    input  gba_io_pkg::io_data_t led_reg3,
    input  gba_io_pkg::keys_t    buttons,
    output logic [7:0]           ld
);

    gba_io_pkg::io_data_t sel_word;

    always_comb begin
        unique case (sw[3:2])
            2'd0: sel_word = led_reg0;
            2'd1: sel_word = led_reg1;
            2'd2: sel_word = led_reg2;
            2'd3: sel_word = led_reg3;
        endcase
    end

    always_comb begin
        if (sw[7:4] == 4'h0) begin
            ld = sel_word[{sw[1:0], 3'b000} +: 8];
        end else if (sw[7]) begin
            ld = ~buttons[15:8];
        end else begin
            ld = ~buttons[7:0];
        end
    end

endmodule

// ==== rtl/gba_io_top.sv ====
// Memory-mapped I/O block: register bank, four cascadable timers, the
// interrupt controller and the debug LED selector, all on one clock.
// The bus has no wait states: writes land at the edge, reads are
// combinational.
`timescale 1ns/1ns

`include "gba_io_cfg.svh"

module gba_io_top (
    input  logic                  clock,
    input  logic                  reset,
    input  gba_io_pkg::io_index_t bus_index,
    input  gba_io_pkg::io_data_t  bus_wdata,
    input  logic                  bus_write,
    output gba_io_pkg::io_data_t  bus_rdata,
    input  gba_io_pkg::keys_t     buttons,
    input  logic [7:0]            sw,
    output logic                  nirq,
    output logic [7:0]            ld
);

    gba_timer_pkg::tm_count_t tm_reload [`NUM_TIMERS];
    gba_timer_pkg::tm_ctrl_t  tm_ctrl [`NUM_TIMERS];
    gba_timer_pkg::tm_count_t tm_count [`NUM_TIMERS];
    logic [`NUM_TIMERS-1:0]   tm_overflow;
    logic [`NUM_TIMERS-1:0]   tm_cascade;
    logic [`NUM_TIMERS-1:0]   timer_irq;
    gba_io_pkg::irq_vec_t     reg_ie;
    gba_io_pkg::irq_vec_t     reg_if;
    gba_io_pkg::irq_vec_t     int_ack;
    logic                     ime;
    gba_io_pkg::io_data_t     led_reg0;
    gba_io_pkg::io_data_t     led_reg1;
    gba_io_pkg::io_data_t     led_reg2;
    gba_io_pkg::io_data_t     led_reg3;

    io_reg_bank i_reg_bank (
        .clock, .reset,
        .bus_index, .bus_wdata, .bus_write, .bus_rdata,
        .tm_reload, .tm_ctrl, .tm_count,
        .reg_ie, .ime, .int_ack, .reg_if, .buttons,
        .led_reg0, .led_reg1, .led_reg2, .led_reg3
    );

    // Timer 0 has nothing to cascade from
    assign tm_cascade = {tm_overflow[`NUM_TIMERS-2:0], 1'b0};

    for (genvar i = 0; i < `NUM_TIMERS; i++) begin : g_timer
        timer_unit i_timer (
            .clock, .reset,
            .reload     (tm_reload[i]),
            .ctrl       (tm_ctrl[i]),
            .cascade_in (tm_cascade[i]),
            .count      (tm_count[i]),
            .overflow   (tm_overflow[i])
        );

        assign timer_irq[i] = tm_overflow[i] && tm_ctrl[i][gba_timer_pkg::TM_IRQ_EN_BIT];
    end

    interrupt_controller i_intc (
        .clock, .reset,
        .timer_irq, .buttons,
        .reg_ie, .ime, .int_ack,
        .reg_if, .nirq
    );

    led_controller i_led (
        .sw,
        .led_reg0, .led_reg1, .led_reg2, .led_reg3,
        .buttons, .ld
    );

endmodule

// ==== testbench/gba_io_tb.sv ====
// Testbench for the I/O block top level.
// Builds a table of bus writes, reads, waits and pin changes, then applies
// it step by step with inputs driven on the falling clock edge. Expected
// values follow the register map and the timer and interrupt timing rules.
`timescale 1ns/1ns

`include "gba_io_cfg.svh"

module gba_io_tb;

    localparam int PERIOD = 40;
    localparam logic [15:0] KEYS_RELEASED = 16'hFFFF;

    typedef enum {OP_WRITE, OP_READ, OP_WAIT, OP_SET_IO, OP_CHECK_LD, OP_WAIT_NIRQ} op_t;

    typedef struct {
        op_t                   op;
        int                    test_id;
        gba_io_pkg::io_index_t index;
        gba_io_pkg::io_data_t  data;
        gba_io_pkg::io_data_t  expected;
    } step_t;

    logic                  clock;
    logic                  reset;
    gba_io_pkg::io_index_t bus_index;
    gba_io_pkg::io_data_t  bus_wdata;
    logic                  bus_write;
    gba_io_pkg::io_data_t  bus_rdata;
    gba_io_pkg::keys_t     buttons;
    logic [7:0]            sw;
    logic                  nirq;
    logic [7:0]            ld;

    step_t steps[$];
    string test_names [7];
    int    checks;
    int    test_errors;
    int    total_errors;
    int    watchdog_cycles;
    bit    table_ready;

    gba_io_top i_dut (
        .clock, .reset,
        .bus_index, .bus_wdata, .bus_write, .bus_rdata,
        .buttons, .sw, .nirq, .ld
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Count after a given number of edges past the enabling write edge
    function automatic logic [15:0] timer_count(input logic [15:0] reload, input int edges,
                                                input int divisor);
        return reload + 16'((edges - 1) / divisor);
    endfunction

    // Overflows seen after a number of increments from a fresh load
    function automatic logic [15:0] overflow_count(input logic [15:0] reload,
                                                   input int increments);
        return 16'(increments / (65536 - int'(reload)));
    endfunction

    task automatic add_step(input op_t op, input int test_id, input int index,
                            input logic [31:0] data, input logic [31:0] expected);
        step_t s;
        s.op       = op;
        s.test_id  = test_id;
        s.index    = 4'(index);
        s.data     = data;
        s.expected = expected;
        steps.push_back(s);
    endtask

    task automatic add_set_io(input int test_id, input logic [7:0] sw_val,
                              input logic [15:0] keys);
        add_step(OP_SET_IO, test_id, 0, {8'h00, sw_val, keys}, 32'h0);
    endtask

    task automatic build_table();
        logic [31:0] led_words [4];
        logic [15:0] reload_a;
        logic [15:0] reload_b;
        logic [15:0] keys;
        logic [31:0] irq_t0;
        logic [31:0] irq_key;
        irq_t0  = 32'h1 << `IRQ_TIMER0_BIT;
        irq_key = 32'h1 << `IRQ_KEYPAD_BIT;
        test_names[1] = "reset values and LED registers";
        test_names[2] = "button bytes and KEYINPUT";
        test_names[3] = "timer 0 prescaler";
        test_names[4] = "timer cascade";
        test_names[5] = "timer interrupt";
        test_names[6] = "keypad interrupt";

        add_step(OP_WAIT_NIRQ, 1, 0, 0, 1);
        for (int w = 0; w < `NUM_IO_REGS; w++) begin
            add_step(OP_READ, 1, w, 0, (w == `KEYINPUT_IDX) ? {16'h0, KEYS_RELEASED} : 0);
        end
        for (int r = 0; r < 4; r++) begin
            led_words[r] = $urandom;
            add_step(OP_WRITE, 1, `LED_REG0_IDX + r, led_words[r], 0);
        end
        for (int r = 0; r < 4; r++) begin
            add_step(OP_READ, 1, `LED_REG0_IDX + r, 0, led_words[r]);
        end
        for (int v = 0; v < 16; v++) begin
            add_set_io(1, 8'(v), KEYS_RELEASED);
            add_step(OP_CHECK_LD, 1, 0, 0, (led_words[v >> 2] >> (8 * (v & 3))) & 32'hFF);
        end

        keys = 16'($urandom);
        add_set_io(2, 8'h80, keys);
        add_step(OP_CHECK_LD, 2, 0, 0, {24'h0, ~keys[15:8]});
        add_set_io(2, 8'h10, keys);
        add_step(OP_CHECK_LD, 2, 0, 0, {24'h0, ~keys[7:0]});
        add_step(OP_READ, 2, `KEYINPUT_IDX, 0, {16'h0, keys});
        // Release and clear whatever keypad flag the pattern raised
        add_set_io(2, 8'h00, KEYS_RELEASED);
        add_step(OP_WRITE, 2, `IE_IF_IDX, irq_key << 16, 0);
        add_step(OP_READ, 2, `IE_IF_IDX, 0, 0);

        reload_a = 16'($urandom & 32'h7FFF);
        reload_b = 16'($urandom & 32'h7FFF);
        add_step(OP_WRITE, 3, `TM0_IDX, {16'h0080, reload_a}, 0);
        add_step(OP_WAIT, 3, 0, 20, 0);
        add_step(OP_READ, 3, `TM0_IDX, 0, {16'h0080, timer_count(reload_a, 20, 1)});
        add_step(OP_WRITE, 3, `TM0_IDX, {16'h0000, reload_b}, 0);
        add_step(OP_WRITE, 3, `TM0_IDX, {16'h0081, reload_b}, 0);
        add_step(OP_WAIT, 3, 0, 200, 0);
        add_step(OP_READ, 3, `TM0_IDX, 0, {16'h0081, timer_count(reload_b, 200, 64)});
        add_step(OP_WAIT, 3, 0, 64, 0);
        add_step(OP_READ, 3, `TM0_IDX, 0, {16'h0081, timer_count(reload_b, 265, 64)});

        // Timer 1 is loaded one edge before timer 0 starts
        add_step(OP_WRITE, 4, `TM0_IDX, 0, 0);
        add_step(OP_WRITE, 4, `TM1_IDX, {16'h0084, 16'h0000}, 0);
        add_step(OP_WRITE, 4, `TM0_IDX, {16'h0080, 16'hFFFE}, 0);
        add_step(OP_WAIT, 4, 0, 30, 0);
        add_step(OP_READ, 4, `TM1_IDX, 0, {16'h0084, overflow_count(16'hFFFE, 29)});

        add_step(OP_WRITE, 5, `TM1_IDX, 0, 0);
        add_step(OP_WRITE, 5, `TM0_IDX, 0, 0);
        add_step(OP_READ, 5, `IE_IF_IDX, 0, 0);
        add_step(OP_WRITE, 5, `TM0_IDX, {16'h00C0, 16'hFFFE}, 0);
        add_step(OP_WAIT, 5, 0, 3, 0);
        add_step(OP_WRITE, 5, `TM0_IDX, {16'h0000, 16'hFFFE}, 0);
        add_step(OP_READ, 5, `IE_IF_IDX, 0, irq_t0 << 16);
        add_step(OP_WAIT_NIRQ, 5, 0, 0, 1);
        add_step(OP_WRITE, 5, `IE_IF_IDX, irq_t0, 0);
        add_step(OP_WAIT, 5, 0, 4, 0);
        add_step(OP_WAIT_NIRQ, 5, 0, 0, 1);
        add_step(OP_WRITE, 5, `IME_IDX, 1, 0);
        add_step(OP_WAIT_NIRQ, 5, 0, 4, 0);
        add_step(OP_WRITE, 5, `IE_IF_IDX, (irq_t0 << 16) | irq_t0, 0);
        add_step(OP_WAIT_NIRQ, 5, 0, 4, 1);
        add_step(OP_READ, 5, `IE_IF_IDX, 0, irq_t0);

        add_set_io(6, 8'h00, 16'hFFFE);
        add_step(OP_WAIT, 6, 0, 2, 0);
        add_step(OP_READ, 6, `IE_IF_IDX, 0, (irq_key << 16) | irq_t0);
        add_step(OP_WRITE, 6, `IE_IF_IDX, (irq_key << 16) | irq_t0, 0);
        add_step(OP_READ, 6, `IE_IF_IDX, 0, irq_t0);
        add_set_io(6, 8'h00, KEYS_RELEASED);
        add_step(OP_WAIT, 6, 0, 2, 0);
        add_step(OP_READ, 6, `IE_IF_IDX, 0, irq_t0);
    endtask

    task automatic run_step(input step_t s);
        int cycles;
        @(negedge clock);
        bus_write = 1'b0;
        case (s.op)
            OP_WRITE: begin
                bus_index = s.index;
                bus_wdata = s.data;
                bus_write = 1'b1;
            end
            OP_READ: begin
                bus_index = s.index;
                #(PERIOD / 4);
                checks++;
                assert (bus_rdata == s.expected) else begin
                    $display("CHECK FAILED: bus_rdata at index %0d got %h expected %h",
                             s.index, bus_rdata, s.expected);
                    test_errors++;
                end
            end
            OP_WAIT: repeat (s.data - 1) @(negedge clock);
            OP_SET_IO: begin
                sw      = s.data[23:16];
                buttons = s.data[15:0];
            end
            OP_CHECK_LD: begin
                #(PERIOD / 4);
                checks++;
                assert (ld == s.expected[7:0]) else begin
                    $display("CHECK FAILED: ld with sw %h got %h expected %h",
                             sw, ld, s.expected[7:0]);
                    test_errors++;
                end
            end
            OP_WAIT_NIRQ: begin
                cycles = 0;
                while (nirq !== s.expected[0] && cycles < s.data) begin
                    @(negedge clock);
                    cycles++;
                end
                checks++;
                assert (nirq === s.expected[0]) else begin
                    $display("nirq did not reach level %0d within %0d cycles",
                             s.expected[0], s.data);
                    test_errors++;
                end
            end
            default: ;
        endcase
    endtask

    task automatic report_test(input int test_id);
        $display("test %0d, %s: %s (%0d errors)", test_id, test_names[test_id],
                 (test_errors == 0) ? "ok" : "failed", test_errors);
        total_errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        wait (table_ready);
        #(watchdog_cycles * PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int seed_result;
        int cur_test;
        seed_result  = $urandom(32'h8f9bf0aa);
        reset        = 1'b1;
        bus_index    = '0;
        bus_wdata    = '0;
        bus_write    = 1'b0;
        buttons      = KEYS_RELEASED;
        sw           = 8'h00;
        checks       = 0;
        test_errors  = 0;
        total_errors = 0;
        build_table();

        // One cycle per step plus every wait and nirq limit
        watchdog_cycles = 16 + 100;
        foreach (steps[i]) begin
            watchdog_cycles += 1;
            if (steps[i].op == OP_WAIT || steps[i].op == OP_WAIT_NIRQ) begin
                watchdog_cycles += int'(steps[i].data);
            end
        end
        table_ready = 1'b1;

        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        cur_test = steps[0].test_id;
        foreach (steps[i]) begin
            if (steps[i].test_id != cur_test) begin
                report_test(cur_test);
                cur_test = steps[i].test_id;
            end
            run_step(steps[i]);
        end
        report_test(cur_test);

        $display("%0d checks, %0d errors", checks, total_errors);
        if (total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
rtl/gba_io_pkg.sv
rtl/gba_timer_pkg.sv
rtl/io_reg_bank.sv
rtl/timer_unit.sv
rtl/interrupt_controller.sv
rtl/led_controller.sv
rtl/gba_io_top.sv
testbench/gba_io_tb.sv
